/* execUnit_defs.svh */
`ifndef EXEC_UNIT_DEFS_SVH
`define EXEC_UNIT_DEFS_SVH

// --------------------
// Datapath sizing.
// --------------------

// Width of every register, operand and result.
`define DATA_W 16

// Number of general purpose registers.
`define REG_CNT 16

// Bits needed to address one register.
`define REG_IDX_W 4

// Immediate field width, sign-extended to DATA_W.
`define IMM_W 6

`endif

/* isaPkg.sv */
`default_nettype none

`include "execUnit_defs.svh"

package isaPkg;

	// --------------------
	// Opcodes.
	// --------------------

	// Values 11 through 31 are undefined and decode as illegal.
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUB  = 5'd1,
		CMP  = 5'd2,
		AND  = 5'd3,
		OR   = 5'd4,
		XOR  = 5'd5,
		NOT  = 5'd6,
		LSH  = 5'd7,
		RSH  = 5'd8,
		ARSH = 5'd9,
		MOV  = 5'd10
	} opcode_e;

	// --------------------
	// Instruction word.
	// --------------------

	// Register form, used when immSel is low.
	typedef struct packed {
		opcode_e                opcode;
		logic                   immSel;
		logic [`REG_IDX_W-1:0]  dst;
		logic [`REG_IDX_W-1:0]  src;
		logic [1:0]             pad;
	} regForm_t;

	// Immediate form. The immediate takes the place of src and pad.
	typedef struct packed {
		opcode_e                opcode;
		logic                   immSel;
		logic [`REG_IDX_W-1:0]  dst;
		logic signed [`IMM_W-1:0] imm;
	} immForm_t;

	// The same 16 bits seen either way.
	typedef union packed {
		regForm_t r;
		immForm_t i;
	} instrWord_t;

endpackage

`default_nettype wire

/* execPkg.sv */
`default_nettype none

`include "execUnit_defs.svh"

package execPkg;

	// Processor status flags with C in bit 0.
	typedef struct packed {
		logic n;
		logic z;
		logic f;
		logic l;
		logic c;
	} aluFlags_t;

	// --------------------
	// Host interface.
	// --------------------

	typedef struct packed {
		isaPkg::instrWord_t instr;
	} execReq_t;

	typedef enum logic {
		OK      = 1'b0,
		ILLEGAL = 1'b1
	} execStatus_e;

	// Flags here are the PSR after the instruction.
	typedef struct packed {
		logic [`DATA_W-1:0] result;
		aluFlags_t          flags;
		execStatus_e        status;
	} execRsp_t;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "execUnit_defs.svh"

module alu (
	input  isaPkg::opcode_e     opcode,
	input  logic [`DATA_W-1:0]  srcVal,
	input  logic [`DATA_W-1:0]  dstVal,
	input  execPkg::aluFlags_t  psr,
	output logic [`DATA_W-1:0]  result,
	output execPkg::aluFlags_t  flags,
	output logic                wrResult,
	output logic                wrFlags,
	output logic                illegal
);
	import isaPkg::*;
	import execPkg::*;

	logic [`DATA_W-1:0] addend;
	logic               carryIn;
	logic [`DATA_W-1:0] sum;
	logic               carryOut;
	logic               overflow;
	logic               unsignedLess;
	logic               signedLess;
	logic               equal;

	// --------------------
	// Shared adder.
	// --------------------

	// SUB adds the inverted source with a carry-in of one.
	always_comb begin
		addend = (opcode == SUB) ? ~srcVal : srcVal;
		carryIn = (opcode == SUB);
		{carryOut, sum} = {1'b0, dstVal} + {1'b0, addend} + {{`DATA_W{1'b0}}, carryIn};
		// Both adder inputs agree in sign but the sum does not.
		overflow = (addend[`DATA_W-1] == dstVal[`DATA_W-1]) &&
			(sum[`DATA_W-1] != dstVal[`DATA_W-1]);
	end

	// Ordering flags compare dst against src.
	assign unsignedLess = dstVal < srcVal;
	assign signedLess = $signed(dstVal) < $signed(srcVal);
	assign equal = dstVal == srcVal;

	// --------------------
	// Operation select.
	// --------------------

	always_comb begin
		result = dstVal;
		flags = psr;
		wrResult = 1'b0;
		wrFlags = 1'b0;
		illegal = 1'b0;
		case (opcode)
			ADD, SUB: begin
				result = sum;
				flags = '{n: signedLess, z: equal, f: overflow, l: unsignedLess, c: carryOut};
				wrResult = 1'b1;
				wrFlags = 1'b1;
			end
			CMP: begin
				// Carry and overflow survive a compare.
				flags = '{n: signedLess, z: equal, f: psr.f, l: unsignedLess, c: psr.c};
				wrFlags = 1'b1;
			end
			AND: begin
				result = srcVal & dstVal;
				wrResult = 1'b1;
			end
			OR: begin
				result = srcVal | dstVal;
				wrResult = 1'b1;
			end
			XOR: begin
				result = srcVal ^ dstVal;
				wrResult = 1'b1;
			end
			NOT: begin
				result = ~srcVal;
				wrResult = 1'b1;
			end
			LSH: begin
				result = {srcVal[`DATA_W-2:0], 1'b0};
				wrResult = 1'b1;
			end
			RSH: begin
				result = {1'b0, srcVal[`DATA_W-1:1]};
				wrResult = 1'b1;
			end
			ARSH: begin
				result = {srcVal[`DATA_W-1], srcVal[`DATA_W-1:1]};
				wrResult = 1'b1;
			end
			MOV: begin
				result = srcVal;
				wrResult = 1'b1;
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "execUnit_defs.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`REG_IDX_W-1:0]  rdIdxA,
	input  logic [`REG_IDX_W-1:0]  rdIdxB,
	output logic [`DATA_W-1:0]     rdValA,
	output logic [`DATA_W-1:0]     rdValB,
	input  logic                   wrEn,
	input  logic [`REG_IDX_W-1:0]  wrIdx,
	input  logic [`DATA_W-1:0]     wrVal
);

	logic [`DATA_W-1:0] regs [`REG_CNT];

	// Reads see the array directly, so a write shows up after the edge.
	assign rdValA = regs[rdIdxA];
	assign rdValB = regs[rdIdxB];

	// One write port.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrVal;
		end
	end

endmodule

`default_nettype wire

/* execCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "execUnit_defs.svh"

module execCtrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req,
	input  execPkg::execReq_t      reqData,
	output logic                   ack,
	output execPkg::execRsp_t      rspData,
	output logic [`REG_IDX_W-1:0]  rdIdxA,
	output logic [`REG_IDX_W-1:0]  rdIdxB,
	input  logic [`DATA_W-1:0]     rdValA,
	input  logic [`DATA_W-1:0]     rdValB,
	output logic                   wrEn,
	output logic [`REG_IDX_W-1:0]  wrIdx,
	output logic [`DATA_W-1:0]     wrVal,
	output isaPkg::opcode_e        opcode,
	output logic [`DATA_W-1:0]     srcVal,
	output logic [`DATA_W-1:0]     dstVal,
	output execPkg::aluFlags_t     psr,
	input  logic [`DATA_W-1:0]     result,
	input  execPkg::aluFlags_t     flags,
	input  logic                   wrResult,
	input  logic                   wrFlags,
	input  logic                   illegal
);
	import isaPkg::*;
	import execPkg::*;

	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		DONE
	} state_e;

	state_e             state;
	instrWord_t         instr;
	logic [`DATA_W-1:0] immVal;
	logic               execCycle;

	// --------------------
	// Decode.
	// --------------------

	// reqData is held stable by the host while req is high.
	assign instr = reqData.instr;
	assign execCycle = (state == EXEC);

	assign immVal = {{(`DATA_W-`IMM_W){instr.i.imm[`IMM_W-1]}}, instr.i.imm};

	assign opcode = instr.r.opcode;
	assign rdIdxA = instr.r.dst;
	assign rdIdxB = instr.r.src;
	assign dstVal = rdValA;
	assign srcVal = instr.r.immSel ? immVal : rdValB;

	// Writeback lands on the edge that ends EXEC.
	assign wrEn = execCycle && wrResult;
	assign wrIdx = instr.r.dst;
	assign wrVal = result;

	// --------------------
	// Handshake FSM and PSR.
	// --------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ack <= 1'b0;
			psr <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state <= EXEC;
					end
				end
				EXEC: begin
					state <= DONE;
					ack <= 1'b1;
					if (wrFlags) begin
						psr <= flags;
					end
				end
				DONE: begin
					// Hold the response until the host lets go.
					if (!req) begin
						state <= IDLE;
						ack <= 1'b0;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Response is captured with the writeback and held through DONE.
	// The ALU passes psr through as flags when it leaves the PSR alone.
	always_ff @(posedge clk) begin
		if (execCycle) begin
			rspData.result <= result;
			rspData.flags <= flags;
			rspData.status <= illegal ? ILLEGAL : OK;
		end
	end

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "execUnit_defs.svh"

module execUnit (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	input  execPkg::execReq_t  reqData,
	output logic               ack,
	output execPkg::execRsp_t  rspData
);
	import isaPkg::*;
	import execPkg::*;

	// Register file ports.
	logic [`REG_IDX_W-1:0] rdIdxA;
	logic [`REG_IDX_W-1:0] rdIdxB;
	logic [`DATA_W-1:0]    rdValA;
	logic [`DATA_W-1:0]    rdValB;
	logic                  wrEn;
	logic [`REG_IDX_W-1:0] wrIdx;
	logic [`DATA_W-1:0]    wrVal;

	// ALU ports.
	opcode_e               opcode;
	logic [`DATA_W-1:0]    srcVal;
	logic [`DATA_W-1:0]    dstVal;
	aluFlags_t             psr;
	logic [`DATA_W-1:0]    result;
	aluFlags_t             flags;
	logic                  wrResult;
	logic                  wrFlags;
	logic                  illegal;

	execCtrl ctrl (
		.clk(clk), .rst(rst),
		.req(req), .reqData(reqData), .ack(ack), .rspData(rspData),
		.rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdValA(rdValA), .rdValB(rdValB),
		.wrEn(wrEn), .wrIdx(wrIdx), .wrVal(wrVal),
		.opcode(opcode), .srcVal(srcVal), .dstVal(dstVal), .psr(psr),
		.result(result), .flags(flags),
		.wrResult(wrResult), .wrFlags(wrFlags), .illegal(illegal)
	);

	regFile regs (
		.clk(clk), .rst(rst),
		.rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdValA(rdValA), .rdValB(rdValB),
		.wrEn(wrEn), .wrIdx(wrIdx), .wrVal(wrVal)
	);

	alu ops (
		.opcode(opcode), .srcVal(srcVal), .dstVal(dstVal), .psr(psr),
		.result(result), .flags(flags),
		.wrResult(wrResult), .wrFlags(wrFlags), .illegal(illegal)
	);

endmodule

`default_nettype wire

/* execUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "execUnit_defs.svh"

module execUnitTb;
	import isaPkg::*;
	import execPkg::*;

	localparam int ACK_LIMIT = 20;
	localparam int RANDOM_COUNT = 200;
	localparam logic [`DATA_W:0] WIDE_ONE = 1;

	logic     clk;
	logic     rst;
	logic     req;
	execReq_t reqData;
	logic     ack;
	execRsp_t rspData;

	// --------------------
	// Directed table.
	// --------------------
	string              tNames[$];
	instrWord_t         tWords[$];
	logic [`DATA_W-1:0] tResults[$];
	aluFlags_t          tFlags[$];
	execStatus_e        tStatus[$];

	// Shadow copy of the register file and PSR.
	logic [`DATA_W-1:0] shadowRegs [`REG_CNT];
	aluFlags_t          shadowPsr;

	logic [31:0] rngState;
	int          testErrors;
	int          passCount;
	int          failCount;
	logic        hung;

	execUnit DUT (
		.clk(clk), .rst(rst), .req(req), .reqData(reqData), .ack(ack), .rspData(rspData)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic instrWord_t regWord(input opcode_e op, input int dst, input int src);
		instrWord_t w;
		w.r.opcode = op;
		w.r.immSel = 1'b0;
		w.r.dst = dst[`REG_IDX_W-1:0];
		w.r.src = src[`REG_IDX_W-1:0];
		w.r.pad = 2'b00;
		return w;
	endfunction

	function automatic instrWord_t immWord(input opcode_e op, input int dst, input int imm);
		instrWord_t w;
		w.i.opcode = op;
		w.i.immSel = 1'b1;
		w.i.dst = dst[`REG_IDX_W-1:0];
		w.i.imm = imm[`IMM_W-1:0];
		return w;
	endfunction

	task automatic addTest(input string name, input instrWord_t word,
		input logic [`DATA_W-1:0] res, input aluFlags_t flg, input execStatus_e st);
		tNames.push_back(name);
		tWords.push_back(word);
		tResults.push_back(res);
		tFlags.push_back(flg);
		tStatus.push_back(st);
	endtask

	// Flags are written n z f l c.
	task automatic buildTable();
		addTest("mov_reset", regWord(MOV, 1, 3), 16'h0000, 5'b00000, OK);
		addTest("movi_neg", immWord(MOV, 2, -1), 16'hFFFF, 5'b00000, OK);
		addTest("movi_one", immWord(MOV, 4, 1), 16'h0001, 5'b00000, OK);
		addTest("mov_copy", regWord(MOV, 5, 2), 16'hFFFF, 5'b00000, OK);
		addTest("add_carry", regWord(ADD, 5, 4), 16'h0000, 5'b10001, OK);
		addTest("rsh_max", regWord(RSH, 6, 2), 16'h7FFF, 5'b10001, OK);
		addTest("add_overflow", regWord(ADD, 6, 4), 16'h8000, 5'b00100, OK);
		addTest("cmp_keep_f", regWord(CMP, 6, 6), 16'h8000, 5'b01100, OK);
		addTest("sub_borrow", regWord(SUB, 1, 4), 16'hFFFF, 5'b10010, OK);
		addTest("sub_carry", regWord(SUB, 2, 4), 16'hFFFE, 5'b10001, OK);
		addTest("cmp_unsigned", regWord(CMP, 4, 1), 16'h0001, 5'b00011, OK);
		addTest("cmp_equal", immWord(CMP, 4, 1), 16'h0001, 5'b01001, OK);
		addTest("cmp_signed", regWord(CMP, 6, 4), 16'h8000, 5'b10001, OK);
		addTest("and_after_cmp", regWord(AND, 6, 6), 16'h8000, 5'b10001, OK);
		addTest("or_imm", immWord(OR, 5, 5), 16'h0005, 5'b10001, OK);
		addTest("xor_reg", regWord(XOR, 5, 1), 16'hFFFA, 5'b10001, OK);
		addTest("and_imm", immWord(AND, 5, -4), 16'hFFF8, 5'b10001, OK);
		addTest("not_reg", regWord(NOT, 7, 5), 16'h0007, 5'b10001, OK);
		addTest("lsh_reg", regWord(LSH, 7, 7), 16'h000E, 5'b10001, OK);
		addTest("rsh_reg", regWord(RSH, 8, 1), 16'h7FFF, 5'b10001, OK);
		addTest("arsh_neg", regWord(ARSH, 9, 6), 16'hC000, 5'b10001, OK);
		addTest("arsh_pos", regWord(ARSH, 9, 8), 16'h3FFF, 5'b10001, OK);
		addTest("illegal_reg", regWord(opcode_e'(5'd20), 9, 1), 16'h3FFF, 5'b10001, ILLEGAL);
		addTest("illegal_imm", immWord(opcode_e'(5'd31), 4, 0), 16'h0001, 5'b10001, ILLEGAL);
		addTest("mov_after_illegal", regWord(MOV, 10, 9), 16'h3FFF, 5'b10001, OK);
	endtask

	// --------------------
	// Reference model.
	// --------------------

	// Predicts one response and advances the shadow state.
	task automatic predict(input instrWord_t word, output logic [`DATA_W-1:0] res,
		output aluFlags_t flg, output execStatus_e st);
		logic [`DATA_W-1:0] dstV;
		logic [`DATA_W-1:0] srcV;
		logic [`DATA_W:0]   wide;
		logic               write;
		int                 immInt;
		dstV = shadowRegs[word.r.dst];
		immInt = $signed(word.i.imm);
		srcV = word.r.immSel ? immInt[`DATA_W-1:0] : shadowRegs[word.r.src];
		res = dstV;
		flg = shadowPsr;
		st = OK;
		write = 1'b1;
		case (word.r.opcode)
			ADD: begin
				wide = {1'b0, dstV} + {1'b0, srcV};
				res = wide[`DATA_W-1:0];
				flg.f = (dstV[`DATA_W-1] == srcV[`DATA_W-1]) && (res[`DATA_W-1] != dstV[`DATA_W-1]);
				flg.c = wide[`DATA_W];
			end
			SUB: begin
				wide = {1'b0, dstV} + {1'b0, ~srcV} + WIDE_ONE;
				res = wide[`DATA_W-1:0];
				flg.f = (dstV[`DATA_W-1] != srcV[`DATA_W-1]) && (res[`DATA_W-1] != dstV[`DATA_W-1]);
				flg.c = wide[`DATA_W];
			end
			CMP: write = 1'b0;
			AND: res = dstV & srcV;
			OR: res = dstV | srcV;
			XOR: res = dstV ^ srcV;
			NOT: res = ~srcV;
			LSH: res = srcV << 1;
			RSH: res = srcV >> 1;
			ARSH: res = $signed(srcV) >>> 1;
			MOV: res = srcV;
			default: begin
				write = 1'b0;
				st = ILLEGAL;
			end
		endcase
		// Ordering flags follow every compare-style operation.
		if (word.r.opcode inside {ADD, SUB, CMP}) begin
			flg.l = dstV < srcV;
			flg.z = dstV == srcV;
			flg.n = $signed(dstV) < $signed(srcV);
		end
		if (write) begin
			shadowRegs[word.r.dst] = res;
		end
		shadowPsr = flg;
	endtask

	// --------------------
	// Checks and handshake.
	// --------------------

	task automatic checkResult(input string name, input logic [`DATA_W-1:0] expVal,
		input logic [`DATA_W-1:0] actVal);
		if (actVal !== expVal) begin
			$display("CHECK FAILED %s result: expected %h, actual %h", name, expVal, actVal);
			testErrors++;
		end
	endtask

	task automatic checkFlags(input string name, input aluFlags_t expVal, input aluFlags_t actVal);
		if (actVal !== expVal) begin
			$display("CHECK FAILED %s flags nzflc: expected %b, actual %b", name, expVal, actVal);
			testErrors++;
		end
	endtask

	task automatic checkStatus(input string name, input execStatus_e expVal,
		input execStatus_e actVal);
		if (actVal !== expVal) begin
			$display("CHECK FAILED %s status: expected %s, actual %s", name, expVal.name(),
				actVal.name());
			testErrors++;
		end
	endtask

	// One four-phase transfer. Called 1 ns after a rising edge.
	task automatic runInstr(input instrWord_t word, output execRsp_t rsp, output logic ok);
		int waited;
		ok = 1'b1;
		reqData.instr = word;
		req = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (!ack && waited < ACK_LIMIT);
		if (!ack) begin
			$display("Timeout: ack did not rise within %0d cycles of req", ACK_LIMIT);
			ok = 1'b0;
			req = 1'b0;
			return;
		end
		// One edge to see req, one more to register ack.
		if (waited != 2) begin
			$display("Handshake error: ack rose %0d cycles after req, expected 2", waited);
			testErrors++;
		end
		rsp = rspData;
		req = 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (ack && waited < ACK_LIMIT);
		if (ack) begin
			$display("Timeout: ack stayed high %0d cycles after req dropped", ACK_LIMIT);
			ok = 1'b0;
		end else if (waited != 1) begin
			$display("Handshake error: ack dropped %0d cycles after req, expected 1", waited);
			testErrors++;
		end
	endtask

	task automatic runTest(input string name, input instrWord_t word,
		input logic [`DATA_W-1:0] res, input aluFlags_t flg, input execStatus_e st);
		execRsp_t rsp;
		logic     ok;
		testErrors = 0;
		runInstr(word, rsp, ok);
		if (!ok) begin
			hung = 1'b1;
			testErrors++;
		end else begin
			checkResult(name, res, rsp.result);
			checkFlags(name, flg, rsp.flags);
			checkStatus(name, st, rsp.status);
		end
		if (testErrors == 0) begin
			passCount++;
			$display("test %s: ok", name);
		end else begin
			failCount++;
			$display("test %s: %0d errors", name, testErrors);
		end
	endtask

	initial begin
		logic [`DATA_W-1:0] expRes;
		aluFlags_t          expFlg;
		execStatus_e        expSt;
		instrWord_t         word;
		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		reqData = '0;
		rngState = 32'hec1e_0915;
		passCount = 0;
		failCount = 0;
		testErrors = 0;
		hung = 1'b0;
		for (int i = 0; i < `REG_CNT; i++) begin
			shadowRegs[i] = '0;
		end
		shadowPsr = '0;
		buildTable();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int i = 0; i < tNames.size() && !hung; i++) begin
			// Keeps the shadow in step for the random phase.
			predict(tWords[i], expRes, expFlg, expSt);
			runTest(tNames[i], tWords[i], tResults[i], tFlags[i], tStatus[i]);
		end

		// Mostly legal opcodes, with an illegal one now and then.
		for (int i = 0; i < RANDOM_COUNT && !hung; i++) begin
			rngState = xorshift(rngState);
			word = rngState[15:0];
			if (rngState[31:29] != 3'b000) begin
				word.r.opcode = opcode_e'(rngState[20:16] % 5'd11);
			end
			predict(word, expRes, expFlg, expSt);
			runTest($sformatf("random_%0d", i), word, expRes, expFlg, expSt);
		end

		$display("%0d tests, %0d passed, %0d failed", passCount + failCount, passCount,
			failCount);
		if (failCount == 0 && !hung) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
isaPkg.sv
execPkg.sv
alu.sv
regFile.sv
execCtrl.sv
execUnit.sv
execUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= execUnitTb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing
LINT_FLAGS ?= --lint-only
BUILD_FLAGS ?= --binary -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
